// File: rtl/amac_defs.svh
`ifndef AMAC_DEFS_SVH
`define AMAC_DEFS_SVH

// Datapath widths
`define AMAC_OP_W   16
`define AMAC_PROD_W 32
`define AMAC_ACC_W  40
`define AMAC_CNT_W  16

// Register bus widths
`define AMAC_REG_AW 3
`define AMAC_REG_DW 32

`define AMAC_REG_MODE   3'd0
`define AMAC_REG_CTRL   3'd1
`define AMAC_REG_ACC_LO 3'd2
`define AMAC_REG_ACC_HI 3'd3
`define AMAC_REG_COUNT  3'd4

`endif

// File: rtl/amac_pkg.sv
`default_nettype none

`include "amac_defs.svh"

package amac_pkg;

    typedef enum logic {
        MODE_EXACT  = 1'b0,
        MODE_APPROX = 1'b1
    } mult_mode_e;

    typedef struct packed {
        logic signed [`AMAC_OP_W-1:0] x;
        logic signed [`AMAC_OP_W-1:0] y;
    } sample_t;

    typedef struct packed {
        logic signed [`AMAC_PROD_W-1:0] value;
    } product_t;

    typedef struct packed {
        mult_mode_e mode;
    } cfg_t;

    typedef struct packed {
        logic [`AMAC_REG_AW-1:0] addr;
        logic [`AMAC_REG_DW-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: rtl/approx_mult16.sv
`timescale 1ns/1ps
`default_nettype none

module approx_mult16 (
    input  logic signed [15:0] x,
    input  logic signed [15:0] y,
    output logic        [31:0] z
);

    // Constant-one bits that sit above the first and last Baugh-Wooley rows
    localparam logic ROW0_MSB  = 1'b1;
    localparam logic ROW15_MSB = 1'b1;

    logic [15:0] pp [16];   // Row i holds y gated by x[i], weight i
    logic [20:0] corr [4];  // Correction vectors that stand in for rows 0 to 5

    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i][14:0] = y[14:0] & {15{x[i]}};
            pp[i][15]   = ~(y[15] & x[i]);
        end
        // The sign row is inverted the other way round
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
    end

    // Sparse half-adder style terms taken from neighbouring low rows
    always_comb begin
        corr[0] = '0;
        corr[1] = '0;
        corr[2] = '0;
        corr[3] = '0;

        corr[0][0]  = pp[0][0];
        corr[0][2]  = pp[0][1] & pp[1][0];
        corr[0][3]  = pp[0][3] ^ pp[1][2];
        corr[0][6]  = pp[0][5] & pp[1][4];
        corr[0][7]  = pp[0][7] ^ pp[1][6];
        corr[0][8]  = pp[4][3] & pp[5][2];
        corr[0][9]  = pp[4][4] & pp[5][3];
        corr[0][11] = pp[0][11] ^ pp[1][10];
        corr[0][12] = pp[2][9] & pp[3][8];
        corr[0][13] = pp[4][9] ^ pp[5][8];
        corr[0][14] = pp[4][10] ^ pp[5][9];
        corr[0][16] = pp[1][15] ^ ROW0_MSB;    // Sum with the row 0 constant
        corr[0][17] = pp[1][15] & ROW0_MSB;    // Its carry
        corr[0][18] = pp[2][15] & pp[3][14];
        corr[0][19] = pp[4][14] & pp[5][13];
        corr[0][20] = pp[4][15] & pp[5][14];

        corr[1][7]  = pp[4][3] ^ pp[5][2];
        corr[1][12] = pp[4][7] & pp[5][6];
        corr[1][16] = pp[2][14] ^ pp[3][13];
        corr[1][17] = pp[2][15] | pp[3][14];
        corr[1][18] = pp[3][15];
        corr[1][19] = pp[4][15] ^ pp[5][14];
        corr[1][20] = pp[5][15];

        corr[2][17] = pp[2][15] ^ pp[3][14];
        corr[2][18] = pp[4][13] & pp[5][12];

        corr[3][17] = pp[4][13] ^ pp[5][12];
        corr[3][18] = pp[4][14] ^ pp[5][13];
    end

    // Rows 6 to 15 go in at full precision, the sum wraps at 32 bits
    always_comb begin
        z = 32'(corr[0]) + 32'(corr[1]) + 32'(corr[2]) + 32'(corr[3]);
        for (int i = 6; i < 15; i++) begin
            z = z + (32'(pp[i]) << i);
        end
        z = z + (32'({ROW15_MSB, pp[15]}) << 15);
    end

endmodule

`default_nettype wire

// File: rtl/mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "amac_defs.svh"

module mult_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  amac_pkg::cfg_t      cfg,
    input  logic                sample_valid,
    input  amac_pkg::sample_t   sample,
    output logic                prod_valid,
    output amac_pkg::product_t  prod
);

    import amac_pkg::*;

    logic        [`AMAC_PROD_W-1:0] approx_prod;
    logic signed [`AMAC_PROD_W-1:0] exact_prod;

    approx_mult16 approx_mult16_inst (
        .x (sample.x),
        .y (sample.y),
        .z (approx_prod)
    );

    assign exact_prod = sample.x * sample.y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= sample_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            prod.value <= (cfg.mode == MODE_APPROX) ? $signed(approx_prod) : exact_prod;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mac_accum.sv
`timescale 1ns/1ps
`default_nettype none

`include "amac_defs.svh"

module mac_accum (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    prod_valid,
    input  amac_pkg::product_t      prod,
    output logic [`AMAC_ACC_W-1:0]  acc,
    output logic [`AMAC_CNT_W-1:0]  count
);

    import amac_pkg::*;

    logic signed [`AMAC_ACC_W-1:0] prod_ext;

    assign prod_ext = prod.value;  // Sign extension to the accumulator width

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc   <= '0;
            count <= '0;
        end else if (clear) begin
            // A product arriving together with the clear is dropped
            acc   <= '0;
            count <= '0;
        end else if (prod_valid) begin
            acc   <= acc + prod_ext;  // Wraps modulo 2**40
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/amac_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "amac_defs.svh"

module amac_cfg_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     reg_wr_en,
    input  amac_pkg::reg_wr_t        reg_wr,
    input  logic                     reg_rd_en,
    input  logic [`AMAC_REG_AW-1:0]  reg_rd_addr,
    input  logic [`AMAC_ACC_W-1:0]   acc,
    input  logic [`AMAC_CNT_W-1:0]   count,
    output amac_pkg::cfg_t           cfg,
    output logic                     clear,
    output logic                     reg_rd_valid,
    output logic [`AMAC_REG_DW-1:0]  reg_rd_data
);

    import amac_pkg::*;

    localparam int HI_W = `AMAC_ACC_W - `AMAC_REG_DW;

    logic [`AMAC_REG_DW-1:0] rd_mux;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.mode <= MODE_EXACT;
            clear    <= 1'b0;
        end else begin
            clear <= reg_wr_en && (reg_wr.addr == `AMAC_REG_CTRL) && reg_wr.data[0];
            if (reg_wr_en && (reg_wr.addr == `AMAC_REG_MODE)) begin
                cfg.mode <= mult_mode_e'(reg_wr.data[0]);
            end
        end
    end

    always_comb begin
        rd_mux = '0;  // Unused addresses read as zero
        case (reg_rd_addr)
            `AMAC_REG_MODE:   rd_mux = {{(`AMAC_REG_DW-1){1'b0}}, cfg.mode};
            `AMAC_REG_ACC_LO: rd_mux = acc[`AMAC_REG_DW-1:0];
            `AMAC_REG_ACC_HI: rd_mux = {{(`AMAC_REG_DW-HI_W){acc[`AMAC_ACC_W-1]}},
                                        acc[`AMAC_ACC_W-1 -: HI_W]};
            `AMAC_REG_COUNT:  rd_mux = {{(`AMAC_REG_DW-`AMAC_CNT_W){1'b0}}, count};
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            reg_rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: rtl/amac_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "amac_defs.svh"

module amac_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_valid,
    input  amac_pkg::sample_t        sample,
    input  logic                     reg_wr_en,
    input  amac_pkg::reg_wr_t        reg_wr,
    input  logic                     reg_rd_en,
    input  logic [`AMAC_REG_AW-1:0]  reg_rd_addr,
    output logic                     reg_rd_valid,
    output logic [`AMAC_REG_DW-1:0]  reg_rd_data,
    output logic                     prod_valid,
    output amac_pkg::product_t       prod
);

    import amac_pkg::*;

    cfg_t                   cfg;
    logic                   clear;
    logic [`AMAC_ACC_W-1:0] acc;
    logic [`AMAC_CNT_W-1:0] count;

    amac_cfg_regs amac_cfg_regs_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr_en    (reg_wr_en),
        .reg_wr       (reg_wr),
        .reg_rd_en    (reg_rd_en),
        .reg_rd_addr  (reg_rd_addr),
        .acc          (acc),
        .count        (count),
        .cfg          (cfg),
        .clear        (clear),
        .reg_rd_valid (reg_rd_valid),
        .reg_rd_data  (reg_rd_data)
    );

    mult_stage mult_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .sample_valid (sample_valid),
        .sample       (sample),
        .prod_valid   (prod_valid),
        .prod         (prod)
    );

    // The accumulator taps the same product that leaves the top level
    mac_accum mac_accum_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .prod_valid (prod_valid),
        .prod       (prod),
        .acc        (acc),
        .count      (count)
    );

endmodule

`default_nettype wire

// File: tb/amac_model.svh
`ifndef AMAC_MODEL_SVH
`define AMAC_MODEL_SVH

// Reference arithmetic for the MAC testbench, included inside the testbench module

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] exact_product(input logic [15:0] a, input logic [15:0] b);
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    wa = $signed(a);  // Sign extension to the product width
    wb = $signed(b);
    return wa * wb;
endfunction

// Baugh-Wooley bit of row (bit of a) and column (bit of b)
function automatic logic pp_bit(input logic [15:0] a, input logic [15:0] b,
                                input int row, input int col);
    logic p;
    p = a[row] & b[col];
    return ((row == 15) != (col == 15)) ? ~p : p;  // Mixed sign terms are inverted
endfunction

function automatic logic [31:0] bit_at(input logic v, input int pos);
    return 32'(v) << pos;
endfunction

function automatic logic [31:0] approx_product(input logic [15:0] a, input logic [15:0] b);
    logic [31:0] s;
    s = 32'h8000_0000;  // Constant one above the sign row
    for (int i = 6; i < 16; i++) begin
        for (int j = 0; j < 16; j++) begin
            s += bit_at(pp_bit(a, b, i, j), i + j);
        end
    end
    // Rows 0 to 5 shrink to these sparse terms, the row 0 constant folded in
    s += bit_at(pp_bit(a, b, 0, 0), 0);
    s += bit_at(pp_bit(a, b, 0, 1) & pp_bit(a, b, 1, 0), 2);
    s += bit_at(pp_bit(a, b, 0, 3) ^ pp_bit(a, b, 1, 2), 3);
    s += bit_at(pp_bit(a, b, 0, 5) & pp_bit(a, b, 1, 4), 6);
    s += bit_at(pp_bit(a, b, 0, 7) ^ pp_bit(a, b, 1, 6), 7);
    s += bit_at(pp_bit(a, b, 4, 3) ^ pp_bit(a, b, 5, 2), 7);
    s += bit_at(pp_bit(a, b, 4, 3) & pp_bit(a, b, 5, 2), 8);
    s += bit_at(pp_bit(a, b, 4, 4) & pp_bit(a, b, 5, 3), 9);
    s += bit_at(pp_bit(a, b, 0, 11) ^ pp_bit(a, b, 1, 10), 11);
    s += bit_at(pp_bit(a, b, 2, 9) & pp_bit(a, b, 3, 8), 12);
    s += bit_at(pp_bit(a, b, 4, 7) & pp_bit(a, b, 5, 6), 12);
    s += bit_at(pp_bit(a, b, 4, 9) ^ pp_bit(a, b, 5, 8), 13);
    s += bit_at(pp_bit(a, b, 4, 10) ^ pp_bit(a, b, 5, 9), 14);
    s += bit_at(~pp_bit(a, b, 1, 15), 16);
    s += bit_at(pp_bit(a, b, 2, 14) ^ pp_bit(a, b, 3, 13), 16);
    s += bit_at(pp_bit(a, b, 1, 15), 17);
    s += bit_at(pp_bit(a, b, 2, 15) | pp_bit(a, b, 3, 14), 17);
    s += bit_at(pp_bit(a, b, 2, 15) ^ pp_bit(a, b, 3, 14), 17);
    s += bit_at(pp_bit(a, b, 4, 13) ^ pp_bit(a, b, 5, 12), 17);
    s += bit_at(pp_bit(a, b, 2, 15) & pp_bit(a, b, 3, 14), 18);
    s += bit_at(pp_bit(a, b, 3, 15), 18);
    s += bit_at(pp_bit(a, b, 4, 13) & pp_bit(a, b, 5, 12), 18);
    s += bit_at(pp_bit(a, b, 4, 14) ^ pp_bit(a, b, 5, 13), 18);
    s += bit_at(pp_bit(a, b, 4, 14) & pp_bit(a, b, 5, 13), 19);
    s += bit_at(pp_bit(a, b, 4, 15) ^ pp_bit(a, b, 5, 14), 19);
    s += bit_at(pp_bit(a, b, 4, 15) & pp_bit(a, b, 5, 14), 20);
    s += bit_at(pp_bit(a, b, 5, 15), 20);
    return s;
endfunction

`endif

// File: tb/amac_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "amac_defs.svh"

module amac_tb;

    import amac_pkg::*;

    `include "amac_model.svh"

    logic        clk;
    logic        rst_n;
    logic        sample_valid;
    sample_t     sample;
    logic        reg_wr_en;
    reg_wr_t     reg_wr;
    logic        reg_rd_en;
    logic [2:0]  reg_rd_addr;
    logic        reg_rd_valid;
    logic [31:0] reg_rd_data;
    logic        prod_valid;
    product_t    prod;

    logic [31:0] exp_prod;    // Driven together with each strobe
    logic [31:0] exp_rd;
    logic [31:0] exp_prod_d;
    logic [31:0] exp_rd_d;
    logic [31:0] rng;
    logic [39:0] model_acc;
    logic [15:0] model_cnt;
    mult_mode_e  model_mode;
    string       test_name;
    int          checks;
    int          errors;
    int          err_start;
    int          tests_run;
    int          tests_failed;
    logic [15:0] corner [4] = '{16'h8000, 16'h7fff, 16'h0000, 16'hffff};

    amac_top amac_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .reg_wr_en    (reg_wr_en),
        .reg_wr       (reg_wr),
        .reg_rd_en    (reg_rd_en),
        .reg_rd_addr  (reg_rd_addr),
        .reg_rd_valid (reg_rd_valid),
        .reg_rd_data  (reg_rd_data),
        .prod_valid   (prod_valid),
        .prod         (prod)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        exp_prod_d <= exp_prod;
        exp_rd_d   <= exp_rd;
    end

    prod_check: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> prod_valid && prod.value == exp_prod_d)
    else begin
        errors++;
        $display("FAIL %s: prod expected %h actual %h (prod_valid %b)", test_name,
                 $sampled(exp_prod_d), $sampled(prod.value), $sampled(prod_valid));
    end

    read_check: assert property (@(posedge clk) disable iff (!rst_n)
        reg_rd_en |=> reg_rd_valid && reg_rd_data == exp_rd_d)
    else begin
        errors++;
        $display("FAIL %s: reg_rd_data expected %h actual %h (reg_rd_valid %b)", test_name,
                 $sampled(exp_rd_d), $sampled(reg_rd_data), $sampled(reg_rd_valid));
    end

    // A product may only follow a sample strobe
    idle_check: assert property (@(posedge clk) disable iff (!rst_n)
        prod_valid |-> $past(sample_valid))
    else begin
        errors++;
        $display("Error in %s: prod_valid went high without a sample before it", test_name);
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic put_sample(input logic [15:0] x, input logic [15:0] y, input bit counted);
        logic [31:0] p;
        p = (model_mode == MODE_APPROX) ? approx_product(x, y) : exact_product(x, y);
        sample_valid = 1'b1;
        sample.x     = x;
        sample.y     = y;
        exp_prod     = p;
        checks++;
        if (counted) begin
            model_acc = model_acc + {{8{p[31]}}, p};
            model_cnt = model_cnt + 1'b1;
        end
    endtask

    task automatic run_random(input int n);
        repeat (n) begin
            step();
            rng = lcg_next(rng);
            put_sample(rng[31:16], rng[15:0], 1'b1);
        end
        step();
        sample_valid = 1'b0;
    endtask

    task automatic run_corners();
        foreach (corner[i]) begin
            foreach (corner[j]) begin
                step();
                put_sample(corner[i], corner[j], 1'b1);
            end
        end
        step();
        sample_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (prod_valid && n < 8) begin
            step();
            n++;
        end
        if (prod_valid) begin
            errors++;
            $display("Timeout in %s: prod_valid still high after %0d cycles", test_name, n);
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        step();
        reg_wr_en   = 1'b1;
        reg_wr.addr = addr;
        reg_wr.data = data;
        step();
        reg_wr_en = 1'b0;
        if (addr == `AMAC_REG_MODE) begin
            model_mode = mult_mode_e'(data[0]);
        end
    endtask

    task automatic read_reg(input logic [2:0] addr, input logic [31:0] expected);
        int n;
        step();
        reg_rd_en   = 1'b1;
        reg_rd_addr = addr;
        exp_rd      = expected;
        checks++;
        step();
        reg_rd_en = 1'b0;
        n = 0;
        while (!reg_rd_valid && n < 8) begin
            step();
            n++;
        end
        if (!reg_rd_valid) begin
            errors++;
            $display("Timeout in %s: no reg_rd_valid for address %0d", test_name, addr);
        end
    endtask

    task automatic read_totals();
        read_reg(`AMAC_REG_ACC_LO, model_acc[31:0]);
        read_reg(`AMAC_REG_ACC_HI, {{24{model_acc[39]}}, model_acc[39:32]});
        read_reg(`AMAC_REG_COUNT, {16'd0, model_cnt});
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        step();  // Lets the last read check fire
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("Test %s done, %0d errors", test_name, errors - err_start);
    endtask

    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        reg_wr_en    = 1'b0;
        reg_wr       = '0;
        reg_rd_en    = 1'b0;
        reg_rd_addr  = '0;
        exp_prod     = '0;
        exp_rd       = '0;
        rng          = 32'h8b4e_b06a;
        model_acc    = '0;
        model_cnt    = '0;
        model_mode   = MODE_EXACT;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset");
        read_reg(`AMAC_REG_MODE, 32'd0);
        read_totals();
        read_reg(3'd6, 32'd0);  // Unused address
        end_test();

        start_test("exact");
        run_random(200);
        run_corners();
        wait_drain();
        end_test();

        start_test("approx");
        write_reg(`AMAC_REG_MODE, 32'd1);
        run_random(200);
        run_corners();
        wait_drain();
        read_reg(`AMAC_REG_MODE, 32'd1);
        end_test();

        start_test("accum");
        write_reg(`AMAC_REG_MODE, 32'd0);
        run_random(40);
        write_reg(`AMAC_REG_MODE, 32'd1);
        run_random(40);
        wait_drain();
        read_totals();
        end_test();

        start_test("clear");
        step();
        reg_wr_en   = 1'b1;
        reg_wr.addr = `AMAC_REG_CTRL;
        reg_wr.data = 32'd1;
        model_acc   = '0;
        model_cnt   = '0;
        rng = lcg_next(rng);
        put_sample(rng[31:16], rng[15:0], 1'b0);  // Its product meets the clear pulse
        step();
        reg_wr_en = 1'b0;
        rng = lcg_next(rng);
        put_sample(rng[31:16], rng[15:0], 1'b1);
        step();
        sample_valid = 1'b0;
        wait_drain();
        read_totals();
        run_random(30);
        wait_drain();
        read_totals();
        end_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
+incdir+tb
rtl/amac_pkg.sv
rtl/approx_mult16.sv
rtl/mult_stage.sv
rtl/mac_accum.sv
rtl/amac_cfg_regs.sv
rtl/amac_top.sv
tb/amac_tb.sv

// File: Bender.yml
package:
  name: amac

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/amac_pkg.sv
      - rtl/approx_mult16.sv
      - rtl/mult_stage.sv
      - rtl/mac_accum.sv
      - rtl/amac_cfg_regs.sv
      - rtl/amac_top.sv
  - target: test
    include_dirs:
      - rtl
      - tb
    files:
      - tb/amac_tb.sv
